// File: include/dmem_params.svh
// sizing for the data-memory unit; RAM depth must be a power of two and read latency at least 1
`ifndef DMEM_PARAMS_SVH
`define DMEM_PARAMS_SVH

// byte address width on both ports
`define DMEM_ADDR_W 32

// number of 32-bit words in the RAM model
// addresses past the last word wrap around
`define DMEM_DEPTH_WORDS 256

// cycles from the accepting edge of a read to its response
`define DMEM_RAM_LATENCY 2

`endif

// File: hdl/dmem_pkg.sv
// shared vector types and access-size codes; size code 3 is undefined and handled as a word
`default_nettype none

`include "dmem_params.svh"

package dmem_pkg;

    typedef logic [`DMEM_ADDR_W-1:0] addr_t;  // byte address
    typedef logic [31:0]             word_t;  // one data word
    typedef logic [1:0]              size_t;  // access size code
    typedef logic [1:0]              lane_t;  // byte offset inside a word

    // access sizes as seen on req_size
    localparam size_t SIZE_B = 2'd0;
    localparam size_t SIZE_H = 2'd1;
    localparam size_t SIZE_W = 2'd2;

endpackage

`default_nettype wire

// File: hdl/dmem_lane_merge.sv
// purely combinational byte-lane steering; rdata_hi only matters when the access crosses a word
`timescale 1ns/1ps
`default_nettype none

module dmem_lane_merge (
    input  dmem_pkg::lane_t offset,
    input  dmem_pkg::size_t size,
    input  dmem_pkg::word_t wdata,
    input  dmem_pkg::word_t rdata_lo,
    input  dmem_pkg::word_t rdata_hi,
    output dmem_pkg::word_t load_data,
    output dmem_pkg::word_t store_lo,
    output dmem_pkg::word_t store_hi
);

    logic [63:0] fetched;    // high word above low word
    logic [4:0]  bit_shift;  // offset in bits
    logic [63:0] shifted;
    logic [7:0]  size_mask;  // byte enables at offset 0
    logic [7:0]  byte_en;    // byte enables across both words
    logic [63:0] wdata_sh;   // store data moved to its lanes
    logic [63:0] merged;

    assign fetched   = {rdata_hi, rdata_lo};
    assign bit_shift = {offset, 3'b000};

    // load window starts at the requested byte, lowest address in 7:0
    assign shifted   = fetched >> bit_shift;
    assign load_data = shifted[31:0];

    always_comb begin
        case (size)
            dmem_pkg::SIZE_B: size_mask = 8'b0000_0001;
            dmem_pkg::SIZE_H: size_mask = 8'b0000_0011;
            default:          size_mask = 8'b0000_1111;  // word
        endcase
    end

    assign byte_en  = size_mask << offset;
    assign wdata_sh = {32'd0, wdata} << bit_shift;

    // new bytes where enabled, fetched bytes everywhere else
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            merged[8*i +: 8] = byte_en[i] ? wdata_sh[8*i +: 8] : fetched[8*i +: 8];
        end
    end

    assign store_lo = merged[31:0];
    assign store_hi = merged[63:32];  // spill into the next word

endmodule

`default_nettype wire

// File: hdl/dmem_access_ctrl.sv
// one access at a time; load bytes past the fetched words are not meaningful
`timescale 1ns/1ps
`default_nettype none

module dmem_access_ctrl (
    input  wire             clk,
    input  wire             reset,
    input  wire             req_valid,
    input  dmem_pkg::addr_t req_addr,
    input  wire             req_wen,
    input  dmem_pkg::size_t req_size,
    input  dmem_pkg::word_t req_wdata,
    output logic            req_ready,
    output logic            resp_valid,
    output dmem_pkg::word_t resp_rdata,
    output logic            mem_req_valid,
    output dmem_pkg::addr_t mem_req_addr,
    output logic            mem_req_wen,
    output dmem_pkg::word_t mem_req_wdata,
    input  wire             mem_req_ready,
    input  wire             mem_resp_valid,
    input  dmem_pkg::word_t mem_resp_rdata
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_RD1,
        S_RD1_WAIT,
        S_RD2,
        S_RD2_WAIT,
        S_MERGE,
        S_WR1,
        S_WR2,
        S_RESP
    } ctrl_state_t;

    ctrl_state_t state, state_nxt;

    // captured request
    dmem_pkg::addr_t req_addr_q;
    logic            req_wen_q;
    dmem_pkg::size_t req_size_q;
    dmem_pkg::word_t req_wdata_q;

    dmem_pkg::word_t rdata_lo_q, rdata_hi_q;  // fetched words
    dmem_pkg::word_t store_lo_q, store_hi_q;  // words to write back
    dmem_pkg::word_t load_q;

    dmem_pkg::word_t load_data, store_lo, store_hi;
    dmem_pkg::addr_t aligned_addr;
    logic            crosses_q;

    function automatic logic is_word(input dmem_pkg::size_t size);
        is_word = (size != dmem_pkg::SIZE_B) && (size != dmem_pkg::SIZE_H);
    endfunction

    // true when the bytes run into the next word
    function automatic logic crosses_word(input dmem_pkg::size_t size,
                                          input dmem_pkg::lane_t offset);
        crosses_word = (is_word(size) && offset != 2'd0) ||
                       (size == dmem_pkg::SIZE_H && offset == 2'd3);
    endfunction

    assign aligned_addr = req_addr_q & ~dmem_pkg::addr_t'(3);
    assign crosses_q    = crosses_word(req_size_q, req_addr_q[1:0]);

    dmem_lane_merge u_lane_merge (
        .offset    (req_addr_q[1:0]),
        .size      (req_size_q),
        .wdata     (req_wdata_q),
        .rdata_lo  (rdata_lo_q),
        .rdata_hi  (rdata_hi_q),
        .load_data (load_data),
        .store_lo  (store_lo),
        .store_hi  (store_hi)
    );

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (req_valid) begin
                    // aligned word store goes straight to the write
                    if (req_wen && is_word(req_size) && req_addr[1:0] == 2'd0)
                        state_nxt = S_WR1;
                    else
                        state_nxt = S_RD1;
                end
            end
            S_RD1:      if (mem_req_ready) state_nxt = S_RD1_WAIT;
            S_RD1_WAIT: if (mem_resp_valid) state_nxt = crosses_q ? S_RD2 : S_MERGE;
            S_RD2:      if (mem_req_ready) state_nxt = S_RD2_WAIT;
            S_RD2_WAIT: if (mem_resp_valid) state_nxt = S_MERGE;
            S_MERGE:    state_nxt = req_wen_q ? S_WR1 : S_RESP;
            S_WR1:      if (mem_req_ready) state_nxt = crosses_q ? S_WR2 : S_IDLE;
            S_WR2:      if (mem_req_ready) state_nxt = S_IDLE;
            S_RESP:     state_nxt = S_IDLE;
            default:    state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= S_IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (req_valid) begin
                    req_addr_q  <= req_addr;
                    req_wen_q   <= req_wen;
                    req_size_q  <= req_size;
                    req_wdata_q <= req_wdata;
                    store_lo_q  <= req_wdata;  // used as is by an aligned word store
                end
            end
            S_RD1_WAIT: if (mem_resp_valid) rdata_lo_q <= mem_resp_rdata;
            S_RD2_WAIT: if (mem_resp_valid) rdata_hi_q <= mem_resp_rdata;
            S_MERGE: begin
                load_q     <= load_data;
                store_lo_q <= store_lo;
                store_hi_q <= store_hi;
            end
            default: ;
        endcase
    end

    assign req_ready  = (state == S_IDLE);
    assign resp_valid = (state == S_RESP);
    assign resp_rdata = load_q;

    assign mem_req_valid = (state == S_RD1) || (state == S_RD2) ||
                           (state == S_WR1) || (state == S_WR2);
    assign mem_req_addr  = (state == S_RD2 || state == S_WR2) ?
                           aligned_addr + dmem_pkg::addr_t'(4) : aligned_addr;
    assign mem_req_wen   = (state == S_WR1) || (state == S_WR2);
    assign mem_req_wdata = (state == S_WR2) ? store_hi_q : store_lo_q;

    // memory request held until the RAM takes it
    a_mem_req_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr) &&
            $stable(mem_req_wen) && $stable(mem_req_wdata))
        else $error("memory request changed before it was accepted");

    a_resp_pulse: assert property (@(posedge clk) disable iff (reset)
        resp_valid |=> !resp_valid)
        else $error("resp_valid held for more than one cycle");

    // a read response that lands outside a wait state would be lost
    a_mem_resp_expected: assert property (@(posedge clk) disable iff (reset)
        mem_resp_valid |-> (state == S_RD1_WAIT || state == S_RD2_WAIT))
        else $error("memory response arrived while no read was waiting");

endmodule

`default_nettype wire

// File: hdl/word_ram.sv
// word RAM model, index is the word address modulo the depth; one read in flight at a time
`timescale 1ns/1ps
`default_nettype none

`include "dmem_params.svh"

module word_ram (
    input  wire             clk,
    input  wire             reset,
    input  wire             mem_req_valid,
    input  dmem_pkg::addr_t mem_req_addr,
    input  wire             mem_req_wen,
    input  dmem_pkg::word_t mem_req_wdata,
    output logic            mem_req_ready,
    output logic            mem_resp_valid,
    output dmem_pkg::word_t mem_resp_rdata
);

    localparam int IDX_W = $clog2(`DMEM_DEPTH_WORDS);
    localparam int CNT_W = $clog2(`DMEM_RAM_LATENCY + 1);

    dmem_pkg::word_t mem [`DMEM_DEPTH_WORDS];

    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] rd_idx_q;  // word of the pending read
    logic [CNT_W-1:0] count;     // cycles left until the response
    logic             accept;

    assign idx           = mem_req_addr[IDX_W+1:2];  // byte lanes dropped
    assign mem_req_ready = (count == '0);
    assign accept        = mem_req_valid && mem_req_ready;

    // RAM starts out all zero
    initial begin
        for (int i = 0; i < `DMEM_DEPTH_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && mem_req_wen)
            mem[idx] <= mem_req_wdata;
        if (accept && !mem_req_wen)
            rd_idx_q <= idx;
        if (count == CNT_W'(1))
            mem_resp_rdata <= mem[rd_idx_q];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count          <= '0;
            mem_resp_valid <= 1'b0;
        end else begin
            mem_resp_valid <= (count == CNT_W'(1));
            if (accept && !mem_req_wen)
                count <= CNT_W'(`DMEM_RAM_LATENCY);
            else if (count != '0)
                count <= count - CNT_W'(1);
        end
    end

    a_resp_one_cycle: assert property (@(posedge clk) disable iff (reset)
        mem_resp_valid |=> !mem_resp_valid)
        else $error("mem_resp_valid held for more than one cycle");

endmodule

`default_nettype wire

// File: hdl/unaligned_dmem_top.sv
// controller plus RAM model; one core access at a time, load response has no back-pressure
`timescale 1ns/1ps
`default_nettype none

module unaligned_dmem_top (
    input  wire             clk,
    input  wire             reset,
    input  wire             req_valid,
    input  dmem_pkg::addr_t req_addr,
    input  wire             req_wen,
    input  dmem_pkg::size_t req_size,
    input  dmem_pkg::word_t req_wdata,
    output logic            req_ready,
    output logic            resp_valid,
    output dmem_pkg::word_t resp_rdata
);

    // controller to RAM
    logic            mem_req_valid;
    dmem_pkg::addr_t mem_req_addr;
    logic            mem_req_wen;
    dmem_pkg::word_t mem_req_wdata;
    logic            mem_req_ready;
    logic            mem_resp_valid;
    dmem_pkg::word_t mem_resp_rdata;

    dmem_access_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .req_wen        (req_wen),
        .req_size       (req_size),
        .req_wdata      (req_wdata),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_rdata     (resp_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wen    (mem_req_wen),
        .mem_req_wdata  (mem_req_wdata),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata)
    );

    word_ram u_ram (
        .clk            (clk),
        .reset          (reset),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wen    (mem_req_wen),
        .mem_req_wdata  (mem_req_wdata),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata)
    );

endmodule

`default_nettype wire

// File: tests/unaligned_dmem_tb.sv
// accesses stay inside the RAM so nothing wraps; load bytes past the fetched words are not compared
`timescale 1ns/1ps
`default_nettype none

`include "dmem_params.svh"

module unaligned_dmem_tb;

    localparam int BYTES      = `DMEM_DEPTH_WORDS * 4;
    localparam int BIDX_W     = $clog2(BYTES);
    localparam int WAIT_LIMIT = 50;  // cycles per wait

    logic            clk;
    logic            reset;
    logic            req_valid;
    dmem_pkg::addr_t req_addr;
    logic            req_wen;
    dmem_pkg::size_t req_size;
    dmem_pkg::word_t req_wdata;
    logic            req_ready;
    logic            resp_valid;
    dmem_pkg::word_t resp_rdata;

    logic [7:0]      model [BYTES];  // byte-wide reference of the RAM
    logic            load_pending;
    dmem_pkg::word_t rd;
    logic [31:0]     rnd;

    unaligned_dmem_top UUT (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_wen    (req_wen),
        .req_size   (req_size),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic int size_bytes(input dmem_pkg::size_t size);
        if (size == dmem_pkg::SIZE_B) return 1;
        if (size == dmem_pkg::SIZE_H) return 2;
        return 4;
    endfunction

    function automatic logic [BIDX_W-1:0] byte_index(input dmem_pkg::addr_t a, input int i);
        return BIDX_W'(a + dmem_pkg::addr_t'(i));
    endfunction

    // one request through the handshake, then check or update the model
    task automatic run_access(input logic wen, input dmem_pkg::size_t size,
                              input dmem_pkg::addr_t addr, input dmem_pkg::word_t wdata,
                              output dmem_pkg::word_t rdata);
        int              waited;
        int              offset;
        int              shown;
        logic            done;
        dmem_pkg::word_t expected;
        dmem_pkg::word_t mask;
        req_valid = 1'b1;
        req_wen   = wen;
        req_size  = size;
        req_addr  = addr;
        req_wdata = wdata;
        done      = 1'b0;
        waited    = 0;
        while (!done) begin
            @(negedge clk);
            done = req_ready;
            waited++;
            if (!done && waited > WAIT_LIMIT)
                stop_with_failure("timeout waiting for the request to be accepted");
        end
        @(posedge clk);  // acceptance edge
        #1;
        req_valid = 1'b0;
        done      = 1'b0;
        waited    = 0;
        while (!done) begin
            @(negedge clk);
            done = wen ? req_ready : resp_valid;
            waited++;
            if (!done && waited > WAIT_LIMIT)
                stop_with_failure(wen ? "timeout waiting for the store to finish" :
                                        "timeout waiting for the load response");
        end
        rdata = resp_rdata;
        if (wen) begin
            for (int i = 0; i < size_bytes(size); i++)
                model[byte_index(addr, i)] = wdata[8*i +: 8];
        end else begin
            offset   = int'(addr[1:0]);
            shown    = (offset + size_bytes(size) > 4) ? 4 : 4 - offset;  // fetched bytes only
            mask     = '0;
            expected = '0;
            for (int i = 0; i < shown; i++) begin
                mask[8*i +: 8]     = 8'hff;
                expected[8*i +: 8] = model[byte_index(addr, i)];
            end
            assert ((resp_rdata & mask) === expected)
                else stop_with_failure($sformatf(
                    "mismatch resp_rdata at addr %h: expected %h, actual %h",
                    addr, expected, resp_rdata & mask));
        end
        @(posedge clk);
        #1;
    endtask

    task automatic write_mem(input dmem_pkg::size_t size, input dmem_pkg::addr_t addr,
                             input dmem_pkg::word_t data);
        dmem_pkg::word_t unused_rd;
        run_access(1'b1, size, addr, data, unused_rd);
    endtask

    task automatic read_mem(input dmem_pkg::size_t size, input dmem_pkg::addr_t addr,
                            output dmem_pkg::word_t data);
        run_access(1'b0, size, addr, '0, data);
    endtask

    // tracks loads in flight for the protocol checks
    always_ff @(posedge clk) begin
        if (reset)
            load_pending <= 1'b0;
        else if (req_valid && req_ready && !req_wen)
            load_pending <= 1'b1;
        else if (resp_valid)
            load_pending <= 1'b0;
    end

    a_resp_one_cycle: assert property (@(posedge clk) disable iff (reset)
        resp_valid |=> !resp_valid)
        else stop_with_failure("resp_valid stayed high for more than one cycle");

    a_resp_only_loads: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> load_pending)
        else stop_with_failure("resp_valid pulsed without a load in flight");

    a_busy_after_accept: assert property (@(posedge clk) disable iff (reset)
        req_valid && req_ready |=> !req_ready)
        else stop_with_failure("req_ready stayed high after a request was accepted");

    a_busy_during_load: assert property (@(posedge clk) disable iff (reset)
        load_pending |-> !req_ready)
        else stop_with_failure("req_ready rose before the load response");

    initial begin
        void'($urandom(32'h7769));
        reset     = 1'b1;
        req_valid = 1'b0;
        req_addr  = '0;
        req_wen   = 1'b0;
        req_size  = dmem_pkg::SIZE_W;
        req_wdata = '0;
        for (int i = 0; i < BYTES; i++)
            model[BIDX_W'(i)] = 8'h00;  // RAM starts zeroed
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk);
        assert (req_ready === 1'b1)
            else stop_with_failure($sformatf("mismatch req_ready: expected %h, actual %h",
                                             1'b1, req_ready));
        assert (resp_valid === 1'b0)
            else stop_with_failure($sformatf("mismatch resp_valid: expected %h, actual %h",
                                             1'b0, resp_valid));
        @(posedge clk);
        #1;
        write_mem(dmem_pkg::SIZE_W, 32'h40, 32'h1234_5678);
        read_mem(dmem_pkg::SIZE_W, 32'h40, rd);

        // narrow stores inside one word
        for (int off = 0; off < 4; off++) begin
            write_mem(dmem_pkg::SIZE_W, 32'h80, 32'h1122_3344);
            write_mem(dmem_pkg::SIZE_B, 32'h80 + 32'(off), $urandom);
            read_mem(dmem_pkg::SIZE_W, 32'h80, rd);
        end
        for (int off = 0; off < 3; off++) begin
            write_mem(dmem_pkg::SIZE_W, 32'ha0, 32'ha5a5_a5a5);
            write_mem(dmem_pkg::SIZE_H, 32'ha0 + 32'(off), $urandom);
            read_mem(dmem_pkg::SIZE_W, 32'ha0, rd);
        end

        // word boundary crossings
        write_mem(dmem_pkg::SIZE_W, 32'h0, 32'hcafe_bebe);
        write_mem(dmem_pkg::SIZE_W, 32'h4, 32'hdead_beef);
        read_mem(dmem_pkg::SIZE_W, 32'h1, rd);
        assert (rd === 32'hefca_febe)
            else stop_with_failure($sformatf("mismatch resp_rdata: expected %h, actual %h",
                                             32'hefca_febe, rd));
        for (int a = 0; a < 8; a++)
            read_mem(dmem_pkg::SIZE_W, 32'(a), rd);
        for (int w = 0; w < 12; w++)
            write_mem(dmem_pkg::SIZE_W, 32'h100 + 32'(4 * w), $urandom);
        write_mem(dmem_pkg::SIZE_W, 32'h101, $urandom);
        write_mem(dmem_pkg::SIZE_W, 32'h10a, $urandom);
        write_mem(dmem_pkg::SIZE_W, 32'h117, $urandom);
        write_mem(dmem_pkg::SIZE_H, 32'h123, $urandom);
        for (int a = 32'h100; a < 32'h128; a++) begin
            read_mem(dmem_pkg::SIZE_W, 32'(a), rd);
            read_mem(dmem_pkg::SIZE_H, 32'(a), rd);
        end

        // random mix in a small window so loads hit recent stores
        for (int n = 0; n < 200; n++) begin
            rnd = $urandom;
            run_access(rnd[0], dmem_pkg::size_t'(rnd[9:8] % 2'd3),
                       32'h180 + ($urandom % 32'd120), $urandom, rd);
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: unaligned_dmem.f
+incdir+include
hdl/dmem_pkg.sv
hdl/dmem_lane_merge.sv
hdl/dmem_access_ctrl.sv
hdl/word_ram.sv
hdl/unaligned_dmem_top.sv
tests/unaligned_dmem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log for the result
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module unaligned_dmem_tb \
    -f unaligned_dmem.f \
    -o unaligned_dmem_sim

./obj_dir/unaligned_dmem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
